/* logic/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    NUM_REGS = 32;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Branch conditions and the word access size
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_WORD = 3'b010;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // EX holds the EX/MEM result, MEM holds the MEM/WB data
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_jal;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_addr_t rd;
        word_t     wb_data;
    } mem_wb_t;

endpackage

/* logic/decoder.sv */
module decoder
    import cpu_pkg::*;
(
    input  word_t     i_instr,
    output ctrl_t     o_ctrl,
    output word_t     o_imm,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output reg_addr_t o_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    // funct7 bit 5 selects sub and sra
    assign alt    = i_instr[30];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_sra);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.alu_op = ALU_ADD;
        o_ctrl.funct3 = funct3;
        o_imm         = imm_i;
        o_rs1         = i_instr[19:15];
        o_rs2         = '0;
        o_rd          = '0;
        case (opcode)
            OPC_OP: begin
                o_ctrl.alu_op    = arith_op(funct3, alt);
                o_ctrl.reg_write = 1'b1;
                o_rs2            = i_instr[24:20];
                o_rd             = i_instr[11:7];
            end
            OPC_OP_IMM: begin
                // No subtract with an immediate, only srai uses the alt bit
                o_ctrl.alu_op    = arith_op(funct3, alt && (funct3 == 3'b101));
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_rd             = i_instr[11:7];
            end
            OPC_LUI: begin
                o_ctrl.alu_op    = ALU_PASS_B;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_u;
                o_rs1            = '0;
                o_rd             = i_instr[11:7];
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.mem_read  = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                    o_rd             = i_instr[11:7];
                end
            end
            OPC_STORE: begin
                o_imm = imm_s;
                if (funct3 == F3_WORD) begin
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.mem_write = 1'b1;
                    o_rs2            = i_instr[24:20];
                end
            end
            OPC_BRANCH: begin
                o_ctrl.alu_op    = ALU_SUB;
                o_ctrl.is_branch = 1'b1;
                o_imm            = imm_b;
                o_rs2            = i_instr[24:20];
            end
            OPC_JAL: begin
                o_ctrl.is_jal    = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_j;
                o_rs1            = '0;
                o_rd             = i_instr[11:7];
            end
            default: begin
                // Unknown opcode runs as a no-op
                o_rs1 = '0;
            end
        endcase
    end

endmodule

/* logic/regfile.sv */
module regfile
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      i_reset,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data,
    input  logic      i_we,
    input  reg_addr_t i_rd,
    input  word_t     i_wd
);

    word_t regs [NUM_REGS];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wd;
        end
    end

    // Same-cycle write returns the new value
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_we && (i_rd == addr)) begin
            data = i_wd;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign o_rs1_data = read_port(i_rs1);
    assign o_rs2_data = read_port(i_rs2);

endmodule

/* logic/alu.sv */
module alu
    import cpu_pkg::*;
(
    input  alu_op_e    i_op,
    input  word_t      i_a,
    input  word_t      i_b,
    input  logic [2:0] i_funct3,
    output word_t      o_result,
    output logic       o_taken
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = i_b[4:0];
    assign eq    = (i_a == i_b);
    assign lt_s  = ($signed(i_a) < $signed(i_b));
    assign lt_u  = (i_a < i_b);

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = {31'b0, lt_s};
            ALU_SLTU:   o_result = {31'b0, lt_u};
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_SRA:    o_result = word_t'($signed(i_a) >>> shamt);
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // Branch condition, only meaningful for branch instructions
    always_comb begin
        case (i_funct3)
            F3_BEQ:  o_taken = eq;
            F3_BNE:  o_taken = !eq;
            F3_BLT:  o_taken = lt_s;
            F3_BGE:  o_taken = !lt_s;
            default: o_taken = 1'b0;
        endcase
    end

endmodule

/* logic/hazard_unit.sv */
module hazard_unit
    import cpu_pkg::*;
(
    input  reg_addr_t i_id_rs1,
    input  reg_addr_t i_id_rs2,
    input  id_ex_t    i_id_ex,
    input  ex_mem_t   i_ex_mem,
    input  mem_wb_t   i_mem_wb,
    input  logic      i_branch_taken,
    input  logic      i_dreq,
    input  logic      i_dack,
    output fwd_sel_e  o_fwd_a,
    output fwd_sel_e  o_fwd_b,
    output logic      o_stall,
    output logic      o_flush,
    output logic      o_interlock
);

    logic mem_fwd_ok;
    logic wb_fwd_ok;
    logic load_in_ex;

    // A load in MEM has no data yet, the stall keeps it from being needed
    assign mem_fwd_ok = i_ex_mem.valid && i_ex_mem.ctrl.reg_write
                        && !i_ex_mem.ctrl.mem_read && (i_ex_mem.rd != '0);
    assign wb_fwd_ok  = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.rd != '0);

    // Nearest producer wins
    assign o_fwd_a = (mem_fwd_ok && (i_ex_mem.rd == i_id_ex.rs1)) ? FWD_EX  :
                     (wb_fwd_ok  && (i_mem_wb.rd == i_id_ex.rs1)) ? FWD_MEM : FWD_RF;
    assign o_fwd_b = (mem_fwd_ok && (i_ex_mem.rd == i_id_ex.rs2)) ? FWD_EX  :
                     (wb_fwd_ok  && (i_mem_wb.rd == i_id_ex.rs2)) ? FWD_MEM : FWD_RF;

    assign load_in_ex = i_id_ex.valid && i_id_ex.ctrl.mem_read && (i_id_ex.rd != '0);
    assign o_stall    = load_in_ex
                        && ((i_id_ex.rd == i_id_rs1) || (i_id_ex.rd == i_id_rs2));

    // Redirect on jal or a taken branch
    assign o_flush = i_id_ex.valid
                     && (i_id_ex.ctrl.is_jal || (i_id_ex.ctrl.is_branch && i_branch_taken));

    assign o_interlock = i_dreq && !i_dack;

endmodule

/* logic/cpu_top.sv */
module cpu_top
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  i_reset,
    output word_t o_iaddr,
    input  word_t i_idata,
    output word_t o_daddr,
    output word_t o_dwdata,
    output logic  o_dreq,
    output logic  o_dwrite,
    input  word_t i_drdata,
    input  logic  i_dack
);

    word_t   pc;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // Decode
    ctrl_t     id_ctrl;
    word_t     id_imm;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    word_t     id_rs1_data;
    word_t     id_rs2_data;

    // Execute
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_taken;
    word_t    ex_result;
    word_t    branch_target;

    // Memory
    word_t mem_data;

    logic stall;
    logic flush;
    logic interlock;

    assign o_iaddr = pc;

    // Interlock freezes everything, flush beats stall
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= RESET_PC;
        end else if (!interlock) begin
            if (flush) begin
                pc <= branch_target;
            end else if (!stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            if_id <= '0;
        end else if (!interlock) begin
            if (flush) begin
                if_id <= '0;
            end else if (!stall) begin
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= i_idata;
            end
        end
    end

    decoder u_decoder (
        .i_instr (if_id.instr),
        .o_ctrl  (id_ctrl),
        .o_imm   (id_imm),
        .o_rs1   (id_rs1),
        .o_rs2   (id_rs2),
        .o_rd    (id_rd)
    );

    regfile u_regfile (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_rs1      (id_rs1),
        .i_rs2      (id_rs2),
        .o_rs1_data (id_rs1_data),
        .o_rs2_data (id_rs2_data),
        .i_we       (mem_wb.valid && mem_wb.reg_write),
        .i_rd       (mem_wb.rd),
        .i_wd       (mem_wb.wb_data)
    );

    // Stall and flush both leave a bubble in EX
    always_ff @(posedge clk) begin
        if (i_reset) begin
            id_ex <= '0;
        end else if (!interlock) begin
            if (flush || stall) begin
                id_ex <= '0;
            end else begin
                id_ex.valid    <= if_id.valid;
                id_ex.pc       <= if_id.pc;
                id_ex.ctrl     <= id_ctrl;
                id_ex.rs1      <= id_rs1;
                id_ex.rs2      <= id_rs2;
                id_ex.rd       <= id_rd;
                id_ex.rs1_data <= id_rs1_data;
                id_ex.rs2_data <= id_rs2_data;
                id_ex.imm      <= id_imm;
            end
        end
    end

    always_comb begin
        case (fwd_a)
            FWD_EX:  op_a = ex_mem.result;
            FWD_MEM: op_a = mem_wb.wb_data;
            default: op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_EX:  op_b = ex_mem.result;
            FWD_MEM: op_b = mem_wb.wb_data;
            default: op_b = id_ex.rs2_data;
        endcase
    end

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

    alu u_alu (
        .i_op     (id_ex.ctrl.alu_op),
        .i_a      (op_a),
        .i_b      (alu_b),
        .i_funct3 (id_ex.ctrl.funct3),
        .o_result (alu_result),
        .o_taken  (alu_taken)
    );

    // jal links pc + 4
    assign ex_result     = id_ex.ctrl.is_jal ? (id_ex.pc + 32'd4) : alu_result;
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ex_mem <= '0;
        end else if (!interlock) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= ex_result;
            ex_mem.store_data <= op_b;
        end
    end

    // Request stays put until acknowledged since EX/MEM holds
    assign o_dreq   = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
    assign o_dwrite = ex_mem.valid && ex_mem.ctrl.mem_write;
    assign o_daddr  = ex_mem.result;
    assign o_dwdata = ex_mem.store_data;
    assign mem_data = ex_mem.ctrl.mem_read ? i_drdata : ex_mem.result;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            mem_wb <= '0;
        end else if (!interlock) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.wb_data   <= mem_data;
        end
    end

    hazard_unit u_hazard (
        .i_id_rs1       (id_rs1),
        .i_id_rs2       (id_rs2),
        .i_id_ex        (id_ex),
        .i_ex_mem       (ex_mem),
        .i_mem_wb       (mem_wb),
        .i_branch_taken (alu_taken),
        .i_dreq         (o_dreq),
        .i_dack         (i_dack),
        .o_fwd_a        (fwd_a),
        .o_fwd_b        (fwd_b),
        .o_stall        (stall),
        .o_flush        (flush),
        .o_interlock    (interlock)
    );

endmodule

/* sim/cpu_sva.sv */
module cpu_sva
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  i_reset,
    input logic  o_dreq,
    input logic  o_dwrite,
    input word_t o_daddr,
    input word_t o_dwdata,
    input logic  i_dack,
    input word_t x0_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // Pending request must hold until acknowledged
    a_req_stable: assert property (@(posedge clk) disable iff (i_reset)
        (o_dreq && !i_dack) |=> (o_dreq && $stable(o_daddr) && $stable(o_dwrite)
                                 && $stable(o_dwdata)))
        else $error("data request changed before acknowledge");

    a_reset_idle: assert property (@(posedge clk) i_reset |=> !o_dreq)
        else $error("data request active right after reset");

    // Stored x0 stays zero even when write-back targets it
    a_x0_zero: assert property (@(posedge clk) disable iff (i_reset)
        (x0_data == '0))
        else $error("register zero storage holds a nonzero value");

endmodule

bind cpu_top cpu_sva u_cpu_sva (
    .clk      (clk),
    .i_reset  (i_reset),
    .o_dreq   (o_dreq),
    .o_dwrite (o_dwrite),
    .o_daddr  (o_daddr),
    .o_dwdata (o_dwdata),
    .i_dack   (i_dack),
    .x0_data  (u_regfile.regs[0])
);

/* sim/cpu_tb.sv */
module cpu_tb
    import cpu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    PROG_LEN    = 40;
    localparam int    NUM_TESTS   = 6;
    localparam int    WATCHDOG_NS = NUM_TESTS * PROG_LEN * 40 * 100;
    localparam int    TEST_CYCLES = PROG_LEN * 30;
    localparam word_t DATA_BASE   = 32'h100;
    localparam word_t END_PC      = (PROG_LEN - 1) * 4;

    logic  clk;
    logic  i_reset;
    word_t o_iaddr;
    word_t i_idata;
    word_t o_daddr;
    word_t o_dwdata;
    logic  o_dreq;
    logic  o_dwrite;
    word_t i_drdata;
    logic  i_dack;

    int    seed = 33545;
    word_t imem [256];
    word_t dmem [64];
    word_t model_mem [64];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    st_seen;
    int    wait_cnt;
    int    max_wait;
    int    errors;
    int    tests_failed;
    string test_name;

    cpu_top u_cpu_top (.*);

    assign i_idata = imem[o_iaddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the watchdog stopped the run in test %s", test_name);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic int rnd(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic int dmem_index(input word_t addr);
        return (addr - DATA_BASE) >> 2;
    endfunction

    // Instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t enc_i(input word_t imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_s(input word_t imm, input int rs2);
        return {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input word_t off, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input word_t off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic gen_program(input int mode);
        int hist [3];
        int pending_load;
        int kind;
        int rd;
        int rs1;
        int skip;
        logic [2:0] f3;
        word_t imm;
        pending_load = -1;
        hist = '{1, 2, 3};
        for (int i = 0; i < 256; i++) imem[i] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = (mode == 0) ? 9 : rnd(10);
            skip = 1 + rnd(2);
            rd   = (mode == 5 && rnd(3) == 0) ? 0 : rnd(8);
            rs1  = (mode == 1) ? hist[rnd(3)] : rnd(8);
            if (pending_load >= 0) rs1 = pending_load;
            pending_load = -1;
            if (i < 7) begin
                imem[i] = {word_t'($random(seed))} & 32'hFFFF_F000 | (i + 1) << 7
                          | word_t'(OPC_LUI);
            end else if (i == PROG_LEN - 1) begin
                imem[i] = enc_j(0, 0);
            end else if (i % 5 == 4) begin
                imem[i] = enc_s(DATA_BASE + 4 * rnd(64), rnd(8));
            end else if (mode == 3 && kind < 6 && i + 1 + skip <= PROG_LEN - 1) begin
                if (kind < 4) begin
                    case (rnd(4))
                        0: f3 = 3'b000;
                        1: f3 = 3'b001;
                        2: f3 = 3'b100;
                        default: f3 = 3'b101;
                    endcase
                    imem[i] = enc_b((skip + 1) * 4, rnd(8), rs1, f3);
                end else begin
                    imem[i] = enc_j((skip + 1) * 4, rd);
                end
            end else if ((mode == 2 && kind < 5) || (mode != 0 && kind == 0)) begin
                imem[i] = enc_i(DATA_BASE + 4 * rnd(64), 0, 3'b010, rd, OPC_LOAD);
                pending_load = rd;
            end else begin
                f3 = 3'(rnd(8));
                if (rnd(2) == 0) begin
                    imem[i] = enc_r(((f3 == 0 || f3 == 5) && rnd(2)) ? 7'h20 : 7'h00,
                                    rnd(8), rs1, f3, rd);
                end else begin
                    imm = (f3 == 1) ? rnd(32) :
                          (f3 == 5) ? (rnd(32) | (rnd(2) ? 32'h400 : 0)) : rnd(4096);
                    imem[i] = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
                end
            end
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
        end
    endtask

    // Sequential ISA model over the loaded program
    task automatic run_model();
        word_t x [32];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t v;
        word_t next;
        logic  wr;
        for (int r = 0; r < 32; r++) x[r] = '0;
        pc = RESET_PC;
        while (pc != END_PC) begin
            ins  = imem[pc[9:2]];
            a    = x[ins[19:15]];
            b    = x[ins[24:20]];
            next = pc + 4;
            wr   = 1'b1;
            v    = '0;
            case (ins[6:0])
                OPC_OP:     v = alu_model(ins[14:12], ins[30], a, b);
                OPC_OP_IMM: v = alu_model(ins[14:12], ins[30] && ins[14:12] == 3'd5, a,
                                          {{20{ins[31]}}, ins[31:20]});
                OPC_LUI:    v = {ins[31:12], 12'b0};
                OPC_LOAD:   v = model_mem[dmem_index(a + {{20{ins[31]}}, ins[31:20]})];
                OPC_JAL: begin
                    v    = pc + 4;
                    next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OPC_STORE: begin
                    wr = 1'b0;
                    a  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    model_mem[dmem_index(a)] = b;
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)
                        || (ins[14:12] == 3'b100 && $signed(a) < $signed(b))
                        || (ins[14:12] == 3'b101 && $signed(a) >= $signed(b)))
                        next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 0) x[ins[11:7]] = v;
            pc = next;
        end
    endtask

    // Data memory with random acknowledge delay
    always @(posedge clk) begin
        if (i_reset) begin
            i_dack   <= 1'b0;
            wait_cnt <= 0;
        end else if (i_dack) begin
            if (o_dwrite) dmem[dmem_index(o_daddr)] = o_dwdata;
            i_dack   <= 1'b0;
            wait_cnt <= rnd(max_wait + 1);
        end else if (o_dreq) begin
            if (wait_cnt == 0) begin
                i_dack   <= 1'b1;
                i_drdata <= dmem[dmem_index(o_daddr)];
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!i_reset && o_dreq && o_dwrite && i_dack) begin
            if (st_seen >= exp_addr.size()) begin
                $display("Test %s: unexpected extra store to %h", test_name, o_daddr);
                errors++;
            end else begin
                check_value({test_name, " store address"}, exp_addr[st_seen], o_daddr);
                check_value({test_name, " store data"}, exp_data[st_seen], o_dwdata);
            end
            st_seen++;
        end
    end

    task automatic run_test(input string name, input int mode);
        int errs_before;
        int cycles;
        errs_before = errors;
        test_name   = name;
        @(posedge clk);
        i_reset <= 1'b1;
        @(posedge clk);
        max_wait = (mode == 0) ? 0 : 3;
        gen_program(mode);
        exp_addr.delete();
        exp_data.delete();
        for (int k = 0; k < 64; k++) begin
            // Fill depends on the whole byte address
            dmem[k]      = ((DATA_BASE + 4 * k) * 32'h9E37_79B1) ^ {mode[7:0], 24'h5A5A5A};
            model_mem[k] = dmem[k];
        end
        run_model();
        st_seen = 0;
        @(posedge clk);
        i_reset <= 1'b0;
        cycles = 0;
        while (!(st_seen >= exp_addr.size() && o_iaddr == END_PC)
               && cycles < TEST_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (o_iaddr != END_PC) begin
            $display("Test %s: program did not reach its final jal in %0d cycles", name,
                     TEST_CYCLES);
            errors++;
        end
        repeat (12) @(posedge clk);
        if (st_seen < exp_addr.size()) begin
            $display("Test %s: %0d expected stores never appeared", name,
                     exp_addr.size() - st_seen);
            errors++;
        end
        for (int k = 0; k < 64; k++) check_value({name, " memory"}, model_mem[k], dmem[k]);
        if (errors == errs_before) begin
            $display("Test %s passed, %0d stores", name, st_seen);
        end else begin
            $display("Test %s failed with %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        i_reset      <= 1'b1;
        i_dack       <= 1'b0;
        i_drdata     <= '0;
        errors       = 0;
        tests_failed = 0;
        st_seen      = 0;
        max_wait     = 0;
        run_test("alu", 0);
        run_test("forwarding", 1);
        run_test("load_use", 2);
        run_test("control_flow", 3);
        run_test("back_pressure", 4);
        run_test("register_zero", 5);
        $display("Tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
logic/cpu_pkg.sv
logic/decoder.sv
logic/regfile.sv
logic/alu.sv
logic/hazard_unit.sv
logic/cpu_top.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

/* build.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpu_tb -f all.f -o cpu_sim
output=$(./obj_dir/cpu_sim)
echo "$output"
if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
